//--- hw/hub_pkg.sv
package hub_pkg;

    // Address map
    localparam logic [3:0]  addr_hub     = 4'h1;    // Upper nibble of hub space
    localparam logic [11:0] hub_ctrl_off = 12'h800; // Query register, 0x1800

    // Bus and field widths
    localparam int addr_w  = 16;    // Quadlet address
    localparam int data_w  = 32;    // One quadlet
    localparam int mem_aw  = 9;     // 512 quadlets of hub memory
    localparam int timer_w = 14;    // Cycle timer since query

    // Board ordering
    localparam int board_n = 16;    // Bits in the board mask

    // Timing
    localparam int first_trig_delay = 150; // Roughly 3 us at sysclk for the first board

    // Block layout
    localparam int hub_status_idx = 2;     // Status quadlet, board number in bits 27:24

endpackage

//--- hw/hub_apb_port.sv
`timescale 1ns/1ps

module hub_apb_port (
    input  logic                        sysclk,
    input  logic                        write_trig_reset,
    input  logic [hub_pkg::addr_w-1:0]  paddr,
    input  logic                        psel,
    input  logic                        penable,
    input  logic                        pwrite,
    input  logic [hub_pkg::data_w-1:0]  pwdata,
    input  logic [hub_pkg::data_w-1:0]  rdata,      // From read mux
    output logic [hub_pkg::data_w-1:0]  prdata,
    output logic                        pready,
    output logic                        pslverr,
    output logic                        reg_wen,    // Board write strobe
    output logic [hub_pkg::addr_w-1:0]  reg_raddr,
    output logic [hub_pkg::addr_w-1:0]  reg_waddr,
    output logic [hub_pkg::data_w-1:0]  reg_wdata
);
    import hub_pkg::*;

    logic setup_ph;     // psel without penable
    logic access_ph;    // Transfer completes on this edge
    logic hub_addr;     // Address falls in the hub space

    assign setup_ph  = psel && !penable;
    assign access_ph = psel && penable;
    assign hub_addr  = (paddr[addr_w-1 -: 4] == addr_hub);

    // No wait states, every access phase is ready
    assign pready  = access_ph;
    assign pslverr = access_ph && !hub_addr;    // Foreign space, write dropped below

    // Write strobe lasts exactly the access cycle
    assign reg_wen   = access_ph && pwrite && hub_addr;
    assign reg_waddr = paddr;
    assign reg_wdata = pwdata;

    // Read address tracks paddr so the memory sees it on the setup edge
    assign reg_raddr = paddr;
    assign prdata    = rdata;   // Mux output is valid during access

    // Every access phase is preceded by a setup phase
    a_access_after_setup: assert property (
        @(posedge sysclk) disable iff (write_trig_reset)
        access_ph |-> $past(setup_ph)
    ) else $error("APB access phase without setup phase");

endmodule

//--- hw/hub_collector.sv
`timescale 1ns/1ps

module hub_collector (
    input  logic                                sysclk,
    input  logic                                write_trig_reset,   // Reset and trigger ack
    input  logic                                reg_wen,
    input  logic [hub_pkg::addr_w-1:0]          reg_waddr,
    input  logic [hub_pkg::data_w-1:0]          reg_wdata,
    input  logic [hub_pkg::addr_w-1:0]          reg_raddr,
    input  logic [$clog2(hub_pkg::board_n)-1:0] board_id,
    input  logic                                fw_idle,
    output logic                                mem_wen,
    output logic [hub_pkg::mem_aw-1:0]          mem_waddr,
    output logic [hub_pkg::data_w-1:0]          mem_wdata,
    output logic [hub_pkg::data_w/2-1:0]        sequence_num,       // From query, upper half
    output logic [hub_pkg::board_n-1:0]         board_mask,
    output logic [hub_pkg::board_n-1:0]         board_mask_lower,
    output logic [7:0]                          last_reg_waddr,     // Last quadlet index
    output logic [hub_pkg::mem_aw-1:0]          waddr_offset,       // Base of current block
    output logic [hub_pkg::mem_aw-1:0]          num_written,
    output logic [hub_pkg::timer_w-1:0]         bc_timer,
    output logic [hub_pkg::timer_w-1:0]         bc_read_start,
    output logic                                updated,
    output logic                                write_trig
);
    import hub_pkg::*;

    logic                hub_wen;           // Any write into hub space
    logic                hub_reg_wen;       // Query write to 0x1800
    logic                hub_mem_wen;       // Block write to 0x10NN
    logic [7:0]          wr_idx;            // Quadlet index NN
    logic                new_idx;
    logic [7:0]          block_size;        // Size from the last header
    logic [mem_aw-1:0]   last_write_addr;
    logic [board_n-1:0]  board_updated;
    logic                board_selected;
    logic                write_trig_done;
    logic                seq_error;
    logic                lower_done;        // All lower masked boards reported
    logic                trig_cond;

    assign wr_idx      = reg_waddr[7:0];
    assign hub_wen     = reg_wen && (reg_waddr[addr_w-1 -: 4] == addr_hub);
    assign hub_reg_wen = hub_wen && (reg_waddr[11:0] == hub_ctrl_off);
    assign hub_mem_wen = hub_wen && (reg_waddr[11:8] == 4'd0);

    // Repeated index means the same quadlet again, drop it
    assign new_idx = (wr_idx != last_reg_waddr);
    assign mem_wen = hub_mem_wen && new_idx;

    // Header lands right after the previous block, body after its header
    assign mem_waddr = (wr_idx == 8'd0) ?
                       waddr_offset + mem_aw'(block_size) :
                       waddr_offset + mem_aw'(wr_idx);

    // Header rebuilt as size, seq LSB, seq error, zero, update time
    assign seq_error = (sequence_num != reg_wdata[31:16]);
    assign mem_wdata = (wr_idx == 8'd0) ?
                       {reg_wdata[7:0], reg_wdata[23:16], seq_error, 1'b0, bc_timer} :
                       reg_wdata;

    assign num_written = last_write_addr + mem_aw'(1);  // 0x1FF wraps to zero

    // Empty mask never counts as updated
    assign updated = (board_mask != '0) && (board_updated == board_mask);

    assign board_mask_lower = ((board_n'(1) << board_id) - board_n'(1)) & board_mask;
    assign board_selected   = board_mask[board_id];
    assign lower_done       = ((board_updated & board_mask_lower) == board_mask_lower);

    // First board waits on the timer, the rest on the boards below them
    assign trig_cond = (board_mask_lower == '0) ?
                       (bc_timer == timer_w'(first_trig_delay)) :
                       (lower_done && fw_idle);

    always_ff @(posedge sysclk) begin
        if (write_trig_reset || hub_reg_wen) begin
            bc_timer <= '0;     // Zero on the edge after the query
        end else begin
            bc_timer <= bc_timer + timer_w'(1);
        end
    end

    always_ff @(posedge sysclk) begin
        if (hub_reg_wen) begin
            sequence_num <= reg_wdata[31:16];
        end
    end

    always_ff @(posedge sysclk) begin
        if (write_trig_reset) begin
            board_mask    <= '0;
            board_updated <= '0;
        end else if (hub_reg_wen) begin
            board_mask    <= reg_wdata[board_n-1:0];
            board_updated <= '0;    // New cycle, nobody reported yet
        end else if (mem_wen && (wr_idx == 8'(hub_status_idx))) begin
            board_updated[reg_wdata[27:24]] <= 1'b1;
        end
    end

    // Offset tracking lives for one query cycle
    always_ff @(posedge sysclk) begin
        if (hub_reg_wen) begin
            waddr_offset    <= '0;
            last_reg_waddr  <= 8'hff;   // No index seen yet
            last_write_addr <= '1;
            block_size      <= 8'd0;
        end else if (mem_wen) begin
            last_reg_waddr  <= wr_idx;
            last_write_addr <= mem_waddr;
            if (wr_idx == 8'd0) begin
                block_size   <= reg_wdata[7:0];   // Header size field
                waddr_offset <= waddr_offset + mem_aw'(block_size);
            end
        end
    end

    // Host reading the hub base marks the start of the block read
    always_ff @(posedge sysclk) begin
        if (reg_raddr == {addr_hub, 12'd0}) begin
            bc_read_start <= bc_timer;
        end
    end

    // One trigger per query, held until the FireWire engine acks
    always_ff @(posedge sysclk) begin
        if (write_trig_reset) begin
            write_trig      <= 1'b0;
            write_trig_done <= 1'b0;
        end else if (hub_reg_wen) begin
            write_trig      <= 1'b0;
            write_trig_done <= 1'b0;
        end else if (board_selected && !write_trig_done && trig_cond) begin
            write_trig      <= 1'b1;
            write_trig_done <= 1'b1;
        end
    end

    // A pending trigger belongs to a board that is in the mask
    a_trig_in_mask: assert property (
        @(posedge sysclk) disable iff (write_trig_reset)
        write_trig |-> board_mask[board_id]
    ) else $error("write_trig high for a board outside the mask");

endmodule

//--- hw/hub_mem.sv
`timescale 1ns/1ps

module hub_mem (
    input  logic                        sysclk,
    input  logic                        wen,
    input  logic [hub_pkg::mem_aw-1:0]  waddr,
    input  logic [hub_pkg::data_w-1:0]  wdata,
    input  logic [hub_pkg::mem_aw-1:0]  raddr,
    output logic [hub_pkg::data_w-1:0]  rdata   // One cycle after raddr
);
    import hub_pkg::*;

    // Block RAM, port A writes and port B reads
    logic [data_w-1:0] mem [2**mem_aw];

    always_ff @(posedge sysclk) begin
        if (wen) begin
            mem[waddr] <= wdata;
        end
    end

    // Registered read, address taken on the APB setup edge
    always_ff @(posedge sysclk) begin
        rdata <= mem[raddr];
    end

endmodule

//--- hw/hub_readback.sv
`timescale 1ns/1ps

module hub_readback (
    input  logic [hub_pkg::addr_w-1:0]          reg_raddr,
    input  logic [hub_pkg::data_w-1:0]          mem_rdata,
    input  logic [$clog2(hub_pkg::board_n)-1:0] board_id,
    input  logic [hub_pkg::data_w/2-1:0]        sequence_num,
    input  logic [hub_pkg::board_n-1:0]         board_mask,
    input  logic [hub_pkg::board_n-1:0]         board_mask_lower,
    input  logic [7:0]                          last_reg_waddr,
    input  logic [hub_pkg::mem_aw-1:0]          waddr_offset,
    input  logic [hub_pkg::mem_aw-1:0]          num_written,
    input  logic [hub_pkg::timer_w-1:0]         bc_timer,
    input  logic [hub_pkg::timer_w-1:0]         bc_read_start,
    input  logic                                updated,
    output logic [hub_pkg::data_w-1:0]          rdata
);
    import hub_pkg::*;

    logic              hub_raddr;       // Read inside hub space
    logic              ctrl_raddr;      // 0x1800 to 0x1803
    logic              is_extra;        // Timing quadlet after the last one
    logic              read_addr_ok;    // Index already written
    logic [data_w-1:0] ctrl_rdata;
    logic [data_w-1:0] hub_rdata;

    assign hub_raddr  = (reg_raddr[addr_w-1 -: 4] == addr_hub);
    assign ctrl_raddr = hub_raddr && (reg_raddr[11:2] == hub_ctrl_off[11:2]);

    // Extra field only once the broadcast read is complete
    assign is_extra     = updated && (reg_raddr[mem_aw-1:0] == num_written);
    assign read_addr_ok = (reg_raddr[mem_aw-1:0] < num_written);

    always_comb begin
        case (reg_raddr[1:0])
            2'b00:   ctrl_rdata = {sequence_num, board_mask};                       // 0x1800
            2'b01:   ctrl_rdata = {8'd0, last_reg_waddr, 7'd0, waddr_offset};       // 0x1801
            2'b10:   ctrl_rdata = data_w'(num_written);                             // 0x1802
            default: ctrl_rdata = {12'd0, board_id, board_mask_lower};              // 0x1803
        endcase
    end

    // Memory past the last written quadlet reads as zero
    assign hub_rdata = is_extra     ? {2'b00, bc_read_start, 2'b00, bc_timer} :
                       read_addr_ok ? mem_rdata :
                       '0;

    assign rdata = !hub_raddr ? '0 :
                   ctrl_raddr ? ctrl_rdata :
                   hub_rdata;

    // Timing quadlet only follows a block that carried a status quadlet
    always_comb begin
        if (is_extra) begin
            a_extra_after_status: assert (num_written > mem_aw'(hub_status_idx))
                else $error("extra quadlet selected before any status quadlet");
        end
    end

endmodule

//--- hw/hub_top.sv
`timescale 1ns/1ps

module hub_top (
    input  logic                                sysclk,
    input  logic                                write_trig_reset,
    input  logic [hub_pkg::addr_w-1:0]          paddr,
    input  logic                                psel,
    input  logic                                penable,
    input  logic                                pwrite,
    input  logic [hub_pkg::data_w-1:0]          pwdata,
    output logic [hub_pkg::data_w-1:0]          prdata,
    output logic                                pready,
    output logic                                pslverr,
    input  logic [$clog2(hub_pkg::board_n)-1:0] board_id,
    input  logic                                fw_idle,
    output logic [hub_pkg::data_w/2-1:0]        sequence_num,
    output logic                                write_trig,     // Broadcast request
    output logic                                updated
);
    import hub_pkg::*;

    // Board bus between APB port and the hub
    logic              reg_wen;
    logic [addr_w-1:0] reg_raddr;
    logic [addr_w-1:0] reg_waddr;
    logic [data_w-1:0] reg_wdata;
    logic [data_w-1:0] rdata;

    // Memory ports
    logic              mem_wen;
    logic [mem_aw-1:0] mem_waddr;
    logic [data_w-1:0] mem_wdata;
    logic [data_w-1:0] mem_rdata;

    // Status for readback
    logic [board_n-1:0] board_mask;
    logic [board_n-1:0] board_mask_lower;
    logic [7:0]         last_reg_waddr;
    logic [mem_aw-1:0]  waddr_offset;
    logic [mem_aw-1:0]  num_written;
    logic [timer_w-1:0] bc_timer;
    logic [timer_w-1:0] bc_read_start;

    hub_apb_port hub_apb_port_i (
        .sysclk           (sysclk),
        .write_trig_reset (write_trig_reset),
        .paddr            (paddr),
        .psel             (psel),
        .penable          (penable),
        .pwrite           (pwrite),
        .pwdata           (pwdata),
        .rdata            (rdata),
        .prdata           (prdata),
        .pready           (pready),
        .pslverr          (pslverr),
        .reg_wen          (reg_wen),
        .reg_raddr        (reg_raddr),
        .reg_waddr        (reg_waddr),
        .reg_wdata        (reg_wdata)
    );

    hub_collector hub_collector_i (
        .sysclk           (sysclk),
        .write_trig_reset (write_trig_reset),
        .reg_wen          (reg_wen),
        .reg_waddr        (reg_waddr),
        .reg_wdata        (reg_wdata),
        .reg_raddr        (reg_raddr),
        .board_id         (board_id),
        .fw_idle          (fw_idle),
        .mem_wen          (mem_wen),
        .mem_waddr        (mem_waddr),
        .mem_wdata        (mem_wdata),
        .sequence_num     (sequence_num),
        .board_mask       (board_mask),
        .board_mask_lower (board_mask_lower),
        .last_reg_waddr   (last_reg_waddr),
        .waddr_offset     (waddr_offset),
        .num_written      (num_written),
        .bc_timer         (bc_timer),
        .bc_read_start    (bc_read_start),
        .updated          (updated),
        .write_trig       (write_trig)
    );

    hub_mem hub_mem_i (
        .sysclk (sysclk),
        .wen    (mem_wen),
        .waddr  (mem_waddr),
        .wdata  (mem_wdata),
        .raddr  (reg_raddr[mem_aw-1:0]),    // Quadlet index part of the address
        .rdata  (mem_rdata)
    );

    hub_readback hub_readback_i (
        .reg_raddr        (reg_raddr),
        .mem_rdata        (mem_rdata),
        .board_id         (board_id),
        .sequence_num     (sequence_num),
        .board_mask       (board_mask),
        .board_mask_lower (board_mask_lower),
        .last_reg_waddr   (last_reg_waddr),
        .waddr_offset     (waddr_offset),
        .num_written      (num_written),
        .bc_timer         (bc_timer),
        .bc_read_start    (bc_read_start),
        .updated          (updated),
        .rdata            (rdata)
    );

endmodule

//--- tb/hub_tb_tasks.svh
`ifndef hub_tb_tasks_svh
`define hub_tb_tasks_svh

// Result counters
int errors;
int tests_run;
int test_err_base;      // Error count when the current test began

// Reference model of the hub state
logic [31:0] exp_mem [512];
logic [15:0] exp_seq;
logic [15:0] exp_mask;
logic [15:0] upd_bits;  // Boards whose status quadlet arrived
logic [7:0]  last_idx;
logic [8:0]  blk_base;  // Start of the current block
logic [7:0]  blk_size;
logic [8:0]  written_n;
logic [13:0] acc_timer; // Cycle timer as seen on the coming access edge
int          cyc;
int          q_cyc;     // Cycle count at the query edge

task automatic report_mismatch(input string name, input logic [31:0] got,
                               input logic [31:0] exp);
    errors++;
    $display("mismatch %s: got 0x%h expected 0x%h", name, got, exp);
endtask

task automatic finish_test(input string name);
    tests_run++;
    $display("test %0d %s: %s", tests_run, name,
             (errors == test_err_base) ? "ok" : "failed");
    test_err_base = errors;
endtask

// Applies one accepted write to the model, right after its access edge
task automatic model_write(input logic [15:0] addr, input logic [31:0] data);
    logic [7:0] idx;
    logic [8:0] maddr;
    idx = addr[7:0];
    if (addr[11:0] == hub_ctrl_off) begin
        q_cyc     = cyc;    // Timer is zero after this edge
        exp_seq   = data[31:16];
        exp_mask  = data[15:0];
        upd_bits  = '0;
        last_idx  = 8'hff;
        blk_base  = '0;
        blk_size  = '0;
        written_n = '0;
    end else if (addr[11:8] == 4'h0 && idx != last_idx) begin   // Repeats are dropped
        if (idx == 8'd0) begin
            blk_base = blk_base + 9'(blk_size);  // Block stacks on the previous one
            blk_size = data[7:0];
        end
        maddr = blk_base + 9'(idx);
        exp_mem[maddr] = (idx != 8'd0) ? data :
                         {data[7:0], data[23:16], data[31:16] != exp_seq, 1'b0, acc_timer};
        if (idx == 8'(hub_status_idx)) begin
            upd_bits[data[27:24]] = 1'b1;
        end
        last_idx  = idx;
        written_n = maddr + 9'd1;
    end
endtask

// One APB transfer, setup then access, with the expected read data
task automatic bus_transfer(input logic wr, input logic [15:0] addr, input logic [31:0] data,
                            input logic [31:0] exp, input logic timed);
    @(negedge sysclk);
    psel    = 1'b1;
    penable = 1'b0;
    pwrite  = wr;
    paddr   = addr;
    pwdata  = data;
    @(negedge sysclk);
    penable   = 1'b1;
    acc_timer = 14'(cyc - q_cyc - 1);
    exp_err   = (addr[15:12] != addr_hub);
    exp_rdata = timed ? (exp | 32'(acc_timer)) : exp;   // Timed reads carry the timer
    chk_rdata = !wr;
    @(posedge sysclk);      // Access edge
    if (wr && !exp_err) begin
        model_write(addr, data);
    end
    @(negedge sysclk);
    psel      = 1'b0;
    penable   = 1'b0;
    pwrite    = 1'b0;
    paddr     = '0;
    chk_rdata = 1'b0;
endtask

// Four quadlet block, header size 4, status quadlet names the board
task automatic write_block(input logic [3:0] board, input logic [15:0] hdr_seq);
    logic [31:0] body;
    bus_transfer(1'b1, 16'h1000, {hdr_seq, 8'($urandom), 8'd4}, 32'h0, 1'b0);
    for (int i = 1; i < 4; i++) begin
        body = $urandom;
        if (i == hub_status_idx) begin
            body[27:24] = board;
        end
        bus_transfer(1'b1, 16'h1000 | 16'(i), body, 32'h0, 1'b0);
    end
endtask

task automatic wait_for_trig(input int limit);
    int n;
    n = 0;
    while (!write_trig && n < limit) begin
        @(negedge sysclk);
        n++;
    end
    if (!write_trig) begin
        errors++;
        $display("write_trig did not rise within %0d cycles", limit);
    end
endtask

// FireWire engine acknowledge, also clears the mask
task automatic pulse_ack();
    @(negedge sysclk);
    write_trig_reset = 1'b1;
    @(negedge sysclk);
    write_trig_reset = 1'b0;
    exp_mask = '0;
    upd_bits = '0;
endtask

`endif

//--- tb/hub_tb.sv
`timescale 1ns/1ps

module hub_tb;
    import hub_pkg::*;

    localparam int trig_lat    = 151;   // Query edge to first board trigger edge
    localparam int xfer_cycles = 3;
    localparam int run_cycles  = 8 + xfer_cycles * 39 + trig_lat + 34;    // 39 transfers
    localparam int watchdog_ns = 2 * run_cycles * 20;

    logic              sysclk;
    logic              write_trig_reset;
    logic [addr_w-1:0] paddr;
    logic              psel;
    logic              penable;
    logic              pwrite;
    logic [data_w-1:0] pwdata;
    logic [data_w-1:0] prdata;
    logic              pready;
    logic              pslverr;
    logic [3:0]        board_id;
    logic              fw_idle;
    logic [15:0]       sequence_num;
    logic              write_trig;
    logic              updated;

    logic              chk_rdata;   // Read data check armed
    logic [31:0]       exp_rdata;
    logic              exp_err;
    logic              trig_timed;  // First board test running
    logic              trig_wait;   // Higher board test running
    logic              trig_acked;
    logic [15:0]       seq0;
    logic [13:0]       read_start;  // Timer on the last hub base read

    `include "hub_tb_tasks.svh"

    hub_top hub_top_i (
        .sysclk           (sysclk),
        .write_trig_reset (write_trig_reset),
        .paddr            (paddr),
        .psel             (psel),
        .penable          (penable),
        .pwrite           (pwrite),
        .pwdata           (pwdata),
        .prdata           (prdata),
        .pready           (pready),
        .pslverr          (pslverr),
        .board_id         (board_id),
        .fw_idle          (fw_idle),
        .sequence_num     (sequence_num),
        .write_trig       (write_trig),
        .updated          (updated)
    );

    always #10 sysclk = ~sysclk;
    always @(posedge sysclk) cyc <= cyc + 1;

    initial begin
        #(watchdog_ns);
        $display("timeout after %0d ns, test sequence never finished", watchdog_ns);
        $display("SIMULATION FAILED");
        $finish;
    end

    a_rdata: assert property (@(posedge sysclk) disable iff (write_trig_reset)
        psel && penable && chk_rdata |-> prdata == exp_rdata)
        else report_mismatch("prdata", $sampled(prdata), $sampled(exp_rdata));
    a_pslverr: assert property (@(posedge sysclk) disable iff (write_trig_reset)
        psel && penable |-> pslverr == exp_err && pready)
        else report_mismatch("pslverr", 32'($sampled(pslverr)), 32'($sampled(exp_err)));
    a_sequence: assert property (@(posedge sysclk)    // Held from the first query on
        q_cyc != 0 |-> sequence_num == exp_seq)
        else report_mismatch("sequence_num", 32'($sampled(sequence_num)),
                             32'($sampled(exp_seq)));
    a_updated: assert property (@(posedge sysclk) disable iff (write_trig_reset)
        updated == ((exp_mask != '0) && (upd_bits == exp_mask)))
        else report_mismatch("updated", 32'($sampled(updated)), 32'(!$sampled(updated)));
    a_trig_timed: assert property (@(posedge sysclk)    // Rise shows one sample late
        trig_timed && $rose(write_trig) |-> (cyc - q_cyc) == trig_lat + 1)
        else report_mismatch("write_trig delay", 32'($sampled(cyc) - q_cyc - 1), trig_lat);
    a_trig_ack: assert property (@(posedge sysclk) write_trig_reset |=> !write_trig)
        else report_mismatch("write_trig after ack", 32'h1, 32'h0);
    a_trig_hold: assert property (@(posedge sysclk)
        (trig_wait && !fw_idle) || trig_acked |-> !write_trig)
        else report_mismatch("write_trig early", 32'h1, 32'h0);
    a_trig_rise: assert property (@(posedge sysclk)
        trig_wait && $rose(fw_idle) |=> write_trig)
        else report_mismatch("write_trig rise", 32'h0, 32'h1);

    initial begin
        sysclk           = 1'b0;
        write_trig_reset = 1'b1;    // Reset from time zero
        paddr            = '0;
        psel             = 1'b0;
        penable          = 1'b0;
        pwrite           = 1'b0;
        pwdata           = '0;
        board_id         = 4'd1;
        fw_idle          = 1'b0;
        chk_rdata        = 1'b0;
        exp_rdata        = '0;
        exp_err          = 1'b0;
        trig_timed       = 1'b0;
        trig_wait        = 1'b0;
        trig_acked       = 1'b0;
        cyc              = 0;
        q_cyc            = 0;
        errors           = 0;
        tests_run        = 0;
        test_err_base    = 0;
        exp_mask         = '0;
        upd_bits         = '0;
        exp_seq          = '0;
        last_idx         = 8'hff;
        blk_base         = '0;
        blk_size         = '0;
        written_n        = '0;
        acc_timer        = '0;
        void'($urandom(46));
        repeat (8) @(negedge sysclk);
        write_trig_reset = 1'b0;

        // Query register and id readback, foreign space errors
        seq0 = 16'($urandom);
        bus_transfer(1'b1, 16'h1800, {seq0, 16'h0003}, 32'h0, 1'b0);
        bus_transfer(1'b0, 16'h1800, 32'h0, {seq0, 16'h0003}, 1'b0);
        bus_transfer(1'b0, 16'h1803, 32'h0, {12'd0, 4'd1, 16'h0001}, 1'b0); // Board 0 below
        bus_transfer(1'b0, 16'h2000, 32'h0, 32'h0, 1'b0);
        bus_transfer(1'b1, 16'h2800, 32'h0000_ffff, 32'h0, 1'b0);   // Dropped
        bus_transfer(1'b0, 16'h1800, 32'h0, {seq0, 16'h0003}, 1'b0);
        finish_test("query registers");

        // Two stacked blocks, second header carries a stale sequence
        write_block(4'd0, seq0);
        write_block(4'd1, seq0 + 16'd1);
        for (int a = 0; a < 8; a++) begin
            bus_transfer(1'b0, 16'h1000 | 16'(a), 32'h0, exp_mem[9'(a)], 1'b0);
        end
        bus_transfer(1'b0, 16'h1802, 32'h0, 32'(written_n), 1'b0);
        finish_test("block stacking");

        bus_transfer(1'b1, 16'h1003, $urandom, 32'h0, 1'b0);    // Same index again
        bus_transfer(1'b0, 16'h1007, 32'h0, exp_mem[9'd7], 1'b0);
        bus_transfer(1'b0, 16'h1801, 32'h0, {8'd0, last_idx, 7'd0, blk_base}, 1'b0);
        finish_test("repeated index");

        // All masked boards reported, timing quadlet follows the data
        bus_transfer(1'b0, 16'h1000, 32'h0, exp_mem[9'd0], 1'b0);
        read_start = acc_timer;
        bus_transfer(1'b0, 16'h1000 | 16'(written_n), 32'h0, {2'b00, read_start, 16'd0}, 1'b1);
        bus_transfer(1'b0, 16'h1001 | 16'(written_n), 32'h0, 32'h0, 1'b0);
        finish_test("extra quadlet");

        trig_timed = 1'b1;
        bus_transfer(1'b1, 16'h1800, {seq0, 16'h0006}, 32'h0, 1'b0);  // Board 1 lowest
        wait_for_trig(trig_lat + 10);
        pulse_ack();
        trig_timed = 1'b0;
        finish_test("first board trigger");

        board_id = 4'd2;
        bus_transfer(1'b1, 16'h1800, {seq0, 16'h0007}, 32'h0, 1'b0);
        trig_wait = 1'b1;
        write_block(4'd0, seq0);
        write_block(4'd1, seq0);
        @(negedge sysclk);
        fw_idle = 1'b1;
        wait_for_trig(4);
        trig_wait = 1'b0;
        pulse_ack();
        trig_acked = 1'b1;  // Must stay low with fw_idle still high
        repeat (20) @(negedge sysclk);
        trig_acked = 1'b0;
        finish_test("ordered trigger");

        $display("tests %0d, errors %0d", tests_run, errors);
        if (errors == 0) begin
            $display("SIMULATION PASSED");
        end else begin
            $display("SIMULATION FAILED");
        end
        $finish;
    end

endmodule

//--- build.f
+incdir+tb
hw/hub_pkg.sv
hw/hub_apb_port.sv
hw/hub_collector.sv
hw/hub_mem.sv
hw/hub_readback.sv
hw/hub_top.sv
tb/hub_tb.sv

//--- Makefile
# Verilator simulation of the hub register space
.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build hub_tb, run it into sim.log and look for the pass line"
	@echo "  clean  remove obj_dir and sim.log"
	@echo "  help   this list"

obj_dir/Vhub_tb: build.f hw/*.sv tb/hub_tb.sv tb/hub_tb_tasks.svh
	verilator --binary --timing --assert --timescale 1ns/1ps -f build.f --top-module hub_tb

test: obj_dir/Vhub_tb
	./obj_dir/Vhub_tb | tee sim.log
	@grep -q "SIMULATION PASSED" sim.log

clean:
	rm -rf obj_dir sim.log
